//--- vlog.f
+incdir+rtl
rtl/cpu_pkg.sv
rtl/id_ex_if.sv
rtl/ex_mem_if.sv
rtl/cpu_memory.sv
rtl/fetch_stage.sv
rtl/decode_stage.sv
rtl/execute_stage.sv
rtl/mem_wb_stage.sv
rtl/cpu_top.sv
sim/cpu_chk.sv
sim/tb_cpu.sv

//--- sim/tb_cpu.sv
`timescale 1ns/1ns
`include "cpu_cfg.svh"

module tb_cpu import cpu_pkg::*; ();

    localparam int CLK_PERIOD   = 4;
    localparam int NUM_TESTS    = 5;
    localparam int TEST_CYCLES  = 90;   // reset + run + slack
    localparam int RESET_CYCLES = 5;
    localparam int RUN_CYCLES   = 80;
    localparam int FILL_CYCLES  = 4;    // pipeline still all nops
    localparam int PROG_LEN     = 32;
    localparam int WATCHDOG_NS  = NUM_TESTS * TEST_CYCLES * CLK_PERIOD * 2;

    logic   clk;
    logic   rst_n;
    word_t  in_port;
    word_t  out_port;
    logic   out_write;
    integer seed = 32'h7481_cf27;
    word_t  image [`CPU_MEM_DEPTH];       // program + data image
    word_t  model_rf [`CPU_REG_CNT];
    word_t  model_mem [`CPU_MEM_DEPTH];
    word_t  exp_out [$];
    word_t  got_out [$];
    int     test_err;
    int     err_cnt;
    int     pass_cnt;
    int     fail_cnt;

    cpu_top dut_i (.clk(clk), .rst_n(rst_n), .in_port(in_port), .out_port(out_port),
                   .out_write(out_write));

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic int pick(input int n);
        return $unsigned($random(seed)) % n;
    endfunction

    function automatic word_t encode(input opcode_t op, input reg_idx_t ra, input reg_idx_t rb);
        return {op, ra, rb};
    endfunction

    // opcode mix per test kind
    function automatic opcode_t pick_op(input int kind);
        int r;
        r = pick(8);
        case (kind)
            1:       return (r < 3) ? OP_INC : opcode_t'(OP_MOV + pick(5));   // mov..or
            2:       return (r < 2) ? OP_IN : (r < 4) ? OP_OUT : opcode_t'(OP_MOV + pick(6));
            3:       return (r < 2) ? OP_LDD : (r < 4) ? OP_STD : (r == 4) ? OP_OUT :
                            (r == 5) ? OP_IN : OP_INC;
            default: return (r < 3) ? OP_LDD : (r == 3) ? OP_STD : (r == 4) ? OP_OUT :
                            (r == 5) ? OP_INC : opcode_t'(OP_ADD + pick(2));
        endcase
    endfunction

    task automatic build_image(input int kind);
        opcode_t  op;
        reg_idx_t ra;
        reg_idx_t rb;
        reg_idx_t prev_rd;
        prev_rd = '0;
        for (int a = 0; a < `CPU_MEM_DEPTH; a++) begin
            image[a] = (a >= `CPU_DATA_BASE) ? word_t'($random(seed)) : encode(OP_NOP, '0, '0);
        end
        for (int a = 0; a < PROG_LEN; a++) begin
            op = pick_op(kind);
            ra = reg_idx_t'(pick(4));
            rb = reg_idx_t'(pick(4));
            if (kind == 4) begin                          // read the last destination
                if (op inside {OP_MOV, OP_OUT, OP_LDD}) rb = prev_rd;
                else ra = prev_rd;
                if (op inside {OP_MOV, OP_ADD, OP_SUB, OP_INC, OP_LDD}) prev_rd = ra;
            end
            if (a >= PROG_LEN - 4) begin                  // dump r0..r3
                op = OP_OUT;
                rb = reg_idx_t'(a % 4);
            end
            image[a] = (kind == 0 && a < PROG_LEN - 4) ? word_t'($random(seed))
                                                        : encode(op, ra, rb);
        end
    endtask

    // one instruction at a time, no pipeline
    task automatic run_model(input word_t in_val);
        opcode_t  op;
        reg_idx_t ra;
        reg_idx_t rb;
        addr_t    da;
        model_rf  = '{default: '0};
        model_mem = image;
        exp_out.delete();
        for (int a = 0; a < PROG_LEN; a++) begin
            op = opcode_t'(image[a][7:4]);
            ra = image[a][3:2];
            rb = image[a][1:0];
            da = model_rf[rb] | `CPU_DATA_BASE;          // data half only
            case (op)
                OP_MOV:  model_rf[ra] = model_rf[rb];
                OP_ADD:  model_rf[ra] = model_rf[ra] + model_rf[rb];
                OP_SUB:  model_rf[ra] = model_rf[ra] - model_rf[rb];
                OP_AND:  model_rf[ra] = model_rf[ra] & model_rf[rb];
                OP_OR:   model_rf[ra] = model_rf[ra] | model_rf[rb];
                OP_INC:  model_rf[ra] = model_rf[ra] + 8'd1;
                OP_IN:   model_rf[rb] = in_val;
                OP_OUT:  exp_out.push_back(model_rf[rb]);
                OP_LDD:  model_rf[ra] = model_mem[da];
                OP_STD:  model_mem[da] = model_rf[ra];
                default: ;                                // nop and unused codes
            endcase
        end
    endtask

    task automatic check_out(input string what, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("FAILED at %0t ns: %s out_port 0x%02h, expected 0x%02h",
                     $time, what, got, exp);
            test_err++;
        end
    endtask

    task automatic check_reg(input reg_idx_t r, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("FAILED at %0t ns: r%0d is 0x%02h, expected 0x%02h",
                     $time, r, got, exp);
            test_err++;
        end
    endtask

    task automatic check_mem(input addr_t a, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("FAILED at %0t ns: mem[0x%02h] is 0x%02h, expected 0x%02h",
                     $time, a, got, exp);
            test_err++;
        end
    endtask

    task automatic check_idle(input string when);
        if (out_write !== 1'b0) begin
            $display("out_write was not low %s at %0t ns", when, $time);
            test_err++;
        end
        check_out(when, out_port, '0);
    endtask

    task automatic run_test(input int t);
        word_t in_val;
        string name;
        test_err = 0;
        case (t)
            0:       name = "reset and random mix";
            1:       name = "alu mov inc";
            2:       name = "in and out";
            3:       name = "ldd and std";
            default: name = "hazard chain";
        endcase
        build_image(t);
        in_val = word_t'($random(seed));
        run_model(in_val);
        got_out.delete();
        @(posedge clk);
        rst_n   <= 1'b0;
        in_port <= in_val;                                // held for the whole test
        for (int a = 0; a < `CPU_MEM_DEPTH; a++) begin
            dut_i.mem_i.mem[a] = image[a];
        end
        repeat (RESET_CYCLES - 1) begin
            @(posedge clk);
            @(negedge clk);
            check_idle("in reset");
        end
        @(posedge clk);
        rst_n <= 1'b1;
        for (int cyc = 0; cyc < RUN_CYCLES; cyc++) begin
            @(negedge clk);                               // outputs settled here
            if (cyc < FILL_CYCLES) check_idle("while the pipeline fills");
            else if (out_write === 1'b1) got_out.push_back(out_port);
            else check_out("idle", out_port, '0);
        end
        if (got_out.size() != exp_out.size()) begin
            $display("test %0d: expected %0d output writes but saw %0d",
                     t, exp_out.size(), got_out.size());
            test_err++;
        end
        for (int i = 0; i < exp_out.size() && i < got_out.size(); i++) begin
            check_out($sformatf("write %0d", i), got_out[i], exp_out[i]);
        end
        for (int r = 0; r < `CPU_REG_CNT; r++) begin
            check_reg(reg_idx_t'(r), dut_i.decode_i.rf[r], model_rf[r]);
        end
        for (int a = `CPU_DATA_BASE; a < `CPU_MEM_DEPTH; a++) begin
            check_mem(addr_t'(a), dut_i.mem_i.mem[a], model_mem[a]);
        end
        err_cnt += test_err;
        if (test_err == 0) pass_cnt++;
        else fail_cnt++;
        $display("test %0d %s: %s, %0d outputs, %0d errors", t, name,
                 (test_err == 0) ? "pass" : "fail", got_out.size(), test_err);
    endtask

    initial begin
        rst_n    = 1'b0;
        in_port  = '0;
        err_cnt  = 0;
        pass_cnt = 0;
        fail_cnt = 0;
        for (int t = 0; t < NUM_TESTS; t++) begin
            run_test(t);
        end
        $display("%0d tests, %0d passed, %0d failed, %0d mismatches, %0d assertion failures",
                 NUM_TESTS, pass_cnt, fail_cnt, err_cnt, dut_i.chk_i.assert_fails);
        if (fail_cnt == 0 && err_cnt == 0 && dut_i.chk_i.assert_fails == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    // bound on total run length
    initial begin
        #(WATCHDOG_NS);
        $display("watchdog: tests did not finish within %0d ns", WATCHDOG_NS);
        $display("TEST FAILED");
        $finish;
    end

endmodule

//--- sim/cpu_chk.sv
`timescale 1ns/1ns

module cpu_chk import cpu_pkg::*; (
    input logic  clk,
    input logic  rst_n,
    input logic  stall,
    input addr_t pc,
    input logic  mem_we,
    input logic  out_write
);

    int assert_fails = 0;   // read by the testbench at the end

    // MEM/WB is a nop through reset and one edge past it
    a_out_quiet: assert property (@(posedge clk) !rst_n |=> (!out_write) [*2])
        else begin
            $error("out_write high during reset or right after it");
            assert_fails++;
        end

    // a load-use bubble is a single cycle
    a_stall_once: assert property (@(posedge clk) disable iff (!rst_n) stall |=> !stall)
        else begin
            $error("stall held for two cycles in a row");
            assert_fails++;
        end

    a_pc_hold: assert property (@(posedge clk) disable iff (!rst_n) stall |=> $stable(pc))
        else begin
            $error("pc moved while stall was high");
            assert_fails++;
        end

    a_no_store_in_reset: assert property (@(posedge clk) !rst_n |=> !mem_we)
        else begin
            $error("data write enable high during reset");
            assert_fails++;
        end

endmodule

bind cpu_top cpu_chk chk_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .stall     (stall),
    .pc        (pc),
    .mem_we    (mem_we),
    .out_write (out_write)
);

//--- rtl/cpu_top.sv
`timescale 1ns/1ns

module cpu_top import cpu_pkg::*; (
    input  logic  clk,
    input  logic  rst_n,
    input  word_t in_port,
    output word_t out_port,
    output logic  out_write
);

    // fetch <-> decode
    addr_t    pc;
    word_t    mem_instr;
    word_t    ifid_instr;
    word_t    ifid_in_val;
    logic     stall;

    // write-back path, back to decode and execute
    logic     wb_write;
    reg_idx_t wb_rd;
    word_t    wb_data;

    // data port
    addr_t    mem_addr;
    word_t    mem_wdata;
    logic     mem_we;
    word_t    mem_rdata;

    id_ex_if  id_ex_i ();
    ex_mem_if ex_mem_i ();

    fetch_stage fetch_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .stall     (stall),
        .in_port   (in_port),
        .pc        (pc),
        .mem_instr (mem_instr),
        .instr     (ifid_instr),
        .in_val    (ifid_in_val)
    );

    decode_stage decode_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .instr    (ifid_instr),
        .in_val   (ifid_in_val),
        .stall    (stall),
        .wb_write (wb_write),
        .wb_rd    (wb_rd),
        .wb_data  (wb_data),
        .ex_mem   (ex_mem_i.peek),
        .id_ex    (id_ex_i.producer)
    );

    execute_stage execute_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .id_ex    (id_ex_i.consumer),
        .ex_mem   (ex_mem_i.producer),
        .wb_write (wb_write),
        .wb_rd    (wb_rd),
        .wb_data  (wb_data)
    );

    mem_wb_stage mem_wb_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .ex_mem    (ex_mem_i.consumer),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_we    (mem_we),
        .mem_rdata (mem_rdata),
        .wb_write  (wb_write),
        .wb_rd     (wb_rd),
        .wb_data   (wb_data),
        .out_port  (out_port),
        .out_write (out_write)
    );

    cpu_memory mem_i (
        .clk        (clk),
        .instr_addr (pc),          // port a, instruction
        .instr_data (mem_instr),
        .data_addr  (mem_addr),    // port b, ldd/std
        .data_wdata (mem_wdata),
        .data_we    (mem_we),
        .data_rdata (mem_rdata)
    );

endmodule

//--- rtl/mem_wb_stage.sv
`timescale 1ns/1ns
`include "cpu_cfg.svh"

module mem_wb_stage import cpu_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    ex_mem_if.consumer  ex_mem,
    output addr_t       mem_addr,
    output word_t       mem_wdata,
    output logic        mem_we,
    input  word_t       mem_rdata,
    output logic        wb_write,
    output reg_idx_t    wb_rd,
    output word_t       wb_data,
    output word_t       out_port,
    output logic        out_write
);

    wb_sel_t wb_sel_q;
    logic    io_write_q;
    word_t   alu_q;
    word_t   mem_q;

    assign mem_addr  = addr_t'(ex_mem.alu_res | `CPU_DATA_BASE);   // data half only
    assign mem_wdata = ex_mem.store_data;
    assign mem_we    = ex_mem.mem_write;

    // MEM/WB controls
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wb_write   <= 1'b0;
            wb_rd      <= '0;
            wb_sel_q   <= WB_ALU;
            io_write_q <= 1'b0;
        end else begin
            wb_write   <= ex_mem.reg_write;
            wb_rd      <= ex_mem.rd;
            wb_sel_q   <= ex_mem.wb_sel;
            io_write_q <= ex_mem.io_write;
        end
    end

    always_ff @(posedge clk) begin
        alu_q <= ex_mem.alu_res;   // for out this is the rb value
        mem_q <= mem_rdata;
    end

    assign wb_data   = (wb_sel_q == WB_MEM) ? mem_q : alu_q;
    assign out_write = io_write_q;                   // strobe, so a zero output shows
    assign out_port  = io_write_q ? alu_q : '0;

endmodule

//--- rtl/execute_stage.sv
`timescale 1ns/1ns

module execute_stage import cpu_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    id_ex_if.consumer   id_ex,
    ex_mem_if.producer  ex_mem,
    input  logic        wb_write,
    input  reg_idx_t    wb_rd,
    input  word_t       wb_data
);

    word_t op_a;
    word_t op_b;
    word_t alu_out;

    // EX/MEM first (not a load, data not there yet), then MEM/WB, then decode value
    function automatic word_t fwd(input reg_idx_t src, input word_t dec_val);
        word_t val;
        if (ex_mem.reg_write && !ex_mem.mem_read && ex_mem.rd == src) begin
            val = ex_mem.alu_res;
        end else if (wb_write && wb_rd == src) begin
            val = wb_data;         // alu result or load data
        end else begin
            val = dec_val;
        end
        return val;
    endfunction

    assign op_a = fwd(id_ex.src_a, id_ex.a_val);   // ra
    assign op_b = fwd(id_ex.src_b, id_ex.b_val);   // rb

    always_comb begin
        case (id_ex.alu_op)
            ALU_ADD:     alu_out = op_a + op_b;
            ALU_SUB:     alu_out = op_a - op_b;
            ALU_AND:     alu_out = op_a & op_b;
            ALU_OR:      alu_out = op_a | op_b;
            ALU_INC:     alu_out = op_a + 1'b1;
            ALU_PASS_IN: alu_out = id_ex.in_val;
            default:     alu_out = op_b;            // mov, out value, ldd/std address
        endcase
    end

    // EX/MEM controls
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ex_mem.reg_write <= 1'b0;
            ex_mem.mem_write <= 1'b0;
            ex_mem.io_write  <= 1'b0;
            ex_mem.mem_read  <= 1'b0;
            ex_mem.wb_sel    <= WB_ALU;
            ex_mem.rd        <= '0;
        end else begin
            ex_mem.reg_write <= id_ex.reg_write;
            ex_mem.mem_write <= id_ex.mem_write;
            ex_mem.io_write  <= id_ex.io_write;
            ex_mem.mem_read  <= id_ex.mem_read;
            ex_mem.wb_sel    <= id_ex.wb_sel;
            ex_mem.rd        <= id_ex.rd;
        end
    end

    // EX/MEM payload
    always_ff @(posedge clk) begin
        ex_mem.alu_res    <= alu_out;
        ex_mem.store_data <= op_a;   // std stores ra
    end

endmodule

//--- rtl/decode_stage.sv
`timescale 1ns/1ns
`include "cpu_cfg.svh"

module decode_stage import cpu_pkg::*; (
    input  logic         clk,
    input  logic         rst_n,
    input  word_t        instr,
    input  word_t        in_val,
    output logic         stall,
    input  logic         wb_write,
    input  reg_idx_t     wb_rd,
    input  word_t        wb_data,
    ex_mem_if.peek       ex_mem,
    id_ex_if.producer    id_ex
);

    opcode_t  op;
    reg_idx_t ra;
    reg_idx_t rb;
    logic     uses_a;
    logic     uses_b;
    logic     dec_reg_write;
    alu_op_t  dec_alu_op;
    reg_idx_t dec_rd;
    word_t    rf [`CPU_REG_CNT];
    word_t    ra_val;
    word_t    rb_val;
    logic     load_use;

    assign op = opcode_t'(instr[7:4]);
    assign ra = instr[3:2];
    assign rb = instr[1:0];

    // which operands are really read, so no false stalls
    assign uses_a = op inside {OP_ADD, OP_SUB, OP_AND, OP_OR, OP_INC, OP_STD};
    assign uses_b = op inside {OP_MOV, OP_ADD, OP_SUB, OP_AND, OP_OR, OP_OUT, OP_LDD, OP_STD};
    assign dec_reg_write = op inside {OP_MOV, OP_ADD, OP_SUB, OP_AND, OP_OR, OP_INC,
                                      OP_IN, OP_LDD};
    assign dec_rd = (op == OP_IN) ? rb : ra;   // in writes rb

    always_comb begin
        case (op)
            OP_ADD:  dec_alu_op = ALU_ADD;
            OP_SUB:  dec_alu_op = ALU_SUB;
            OP_AND:  dec_alu_op = ALU_AND;
            OP_OR:   dec_alu_op = ALU_OR;
            OP_INC:  dec_alu_op = ALU_INC;
            OP_IN:   dec_alu_op = ALU_PASS_IN;
            default: dec_alu_op = ALU_PASS_B;  // mov, out, ldd, std address
        endcase
    end

    // register file, written from MEM/WB
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rf <= '{default: '0};
        end else if (wb_write) begin
            rf[wb_rd] <= wb_data;
        end
    end

    // same-cycle write passes straight through
    assign ra_val = (wb_write && wb_rd == ra) ? wb_data : rf[ra];
    assign rb_val = (wb_write && wb_rd == rb) ? wb_data : rf[rb];

    // ldd in EX whose target is read here
    assign load_use = id_ex.mem_read &&
                      ((uses_a && id_ex.rd == ra) || (uses_b && id_ex.rd == rb));

    assign stall = load_use;   // one cycle, the bubble clears id_ex.mem_read

    // ID/EX controls, cleared to a nop on reset or stall
    always_ff @(posedge clk) begin
        if (!rst_n || stall) begin
            id_ex.reg_write <= 1'b0;
            id_ex.mem_read  <= 1'b0;
            id_ex.mem_write <= 1'b0;
            id_ex.io_write  <= 1'b0;
            id_ex.wb_sel    <= WB_ALU;
            id_ex.alu_op    <= ALU_PASS_B;
            id_ex.rd        <= '0;
        end else begin
            id_ex.reg_write <= dec_reg_write;
            id_ex.mem_read  <= (op == OP_LDD);
            id_ex.mem_write <= (op == OP_STD);
            id_ex.io_write  <= (op == OP_OUT);
            id_ex.wb_sel    <= (op == OP_LDD) ? WB_MEM : WB_ALU;
            id_ex.alu_op    <= dec_alu_op;
            id_ex.rd        <= dec_rd;
        end
    end

    // ID/EX payload
    always_ff @(posedge clk) begin
        id_ex.src_a  <= ra;
        id_ex.src_b  <= rb;
        id_ex.a_val  <= ra_val;
        id_ex.b_val  <= rb_val;
        id_ex.in_val <= in_val;
    end

endmodule

//--- rtl/fetch_stage.sv
`timescale 1ns/1ns

module fetch_stage import cpu_pkg::*; (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  stall,       // load-use hold from decode
    input  word_t in_port,
    output addr_t pc,
    input  word_t mem_instr,   // combinational read at pc
    output word_t instr,       // IF/ID
    output word_t in_val       // IF/ID
);

    addr_t pc_plus1;

    assign pc_plus1 = pc + 1'b1;   // wraps at 256

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc     <= '0;
            instr  <= '0;          // opcode 0 is nop
            in_val <= '0;
        end else if (!stall) begin
            pc     <= pc_plus1;
            instr  <= mem_instr;
            in_val <= in_port;     // port travels with its instruction
        end
    end

endmodule

//--- rtl/cpu_memory.sv
`timescale 1ns/1ns
`include "cpu_cfg.svh"

module cpu_memory (
    input  logic                              clk,
    input  logic [$clog2(`CPU_MEM_DEPTH)-1:0] instr_addr,
    output logic [`CPU_DATA_W-1:0]            instr_data,
    input  logic [$clog2(`CPU_MEM_DEPTH)-1:0] data_addr,
    input  logic [`CPU_DATA_W-1:0]            data_wdata,
    input  logic                              data_we,
    output logic [`CPU_DATA_W-1:0]            data_rdata
);

    // program in the lower half, data in the upper half
    logic [`CPU_DATA_W-1:0] mem [`CPU_MEM_DEPTH];

    assign instr_data = mem[instr_addr];   // async read
    assign data_rdata = mem[data_addr];

    always @(posedge clk) begin
        if (data_we) begin
            mem[data_addr] <= data_wdata;
        end
    end

endmodule

//--- rtl/ex_mem_if.sv
`timescale 1ns/1ns

interface ex_mem_if import cpu_pkg::*; ();

    logic     reg_write;
    logic     mem_write;
    logic     io_write;
    logic     mem_read;     // load in MEM, result not yet forwardable
    wb_sel_t  wb_sel;
    reg_idx_t rd;
    word_t    alu_res;      // also the data address before the base bit
    word_t    store_data;   // forwarded ra for std

    modport producer (output reg_write, mem_write, io_write, mem_read, wb_sel, rd,
                      output alu_res, store_data);
    modport consumer (input reg_write, mem_write, io_write, wb_sel, rd, alu_res, store_data);
    modport peek (input mem_read);

endinterface

//--- rtl/id_ex_if.sv
`timescale 1ns/1ns

interface id_ex_if import cpu_pkg::*; ();

    logic     reg_write;
    logic     mem_read;    // ldd, also the load-use marker
    logic     mem_write;
    logic     io_write;    // out
    wb_sel_t  wb_sel;
    alu_op_t  alu_op;
    reg_idx_t rd;          // rb for in, ra otherwise
    reg_idx_t src_a;       // forwarding compare index
    reg_idx_t src_b;
    word_t    a_val;       // regfile read in decode
    word_t    b_val;
    word_t    in_val;      // input port sampled at fetch

    modport producer (output reg_write, mem_read, mem_write, io_write, wb_sel, alu_op,
                      output rd, src_a, src_b, a_val, b_val, in_val);
    modport consumer (input reg_write, mem_read, mem_write, io_write, wb_sel, alu_op,
                      input rd, src_a, src_b, a_val, b_val, in_val);

endinterface

//--- rtl/cpu_pkg.sv
`include "cpu_cfg.svh"

package cpu_pkg;

    typedef logic [`CPU_DATA_W-1:0] word_t;                  // register / alu / port value
    typedef logic [$clog2(`CPU_REG_CNT)-1:0] reg_idx_t;      // ra / rb field
    typedef logic [$clog2(`CPU_MEM_DEPTH)-1:0] addr_t;       // memory address

    // instr[7:4], unlisted codes decode as nop
    typedef enum logic [3:0] {
        OP_NOP = 4'd0,
        OP_MOV = 4'd1,
        OP_ADD = 4'd2,
        OP_SUB = 4'd3,
        OP_AND = 4'd4,
        OP_OR  = 4'd5,
        OP_INC = 4'd6,
        OP_OUT = 4'd7,
        OP_IN  = 4'd8,
        OP_LDD = 4'd9,
        OP_STD = 4'd10
    } opcode_t;

    typedef enum logic [2:0] {
        ALU_PASS_B,   // mov, out, ldd/std address
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_INC,
        ALU_PASS_IN   // in, sampled port value as result
    } alu_op_t;

    typedef enum logic {
        WB_ALU,
        WB_MEM
    } wb_sel_t;

endpackage

//--- rtl/cpu_cfg.svh
`ifndef CPU_CFG_SVH
`define CPU_CFG_SVH

// datapath and instruction width
`define CPU_DATA_W 8

// general purpose registers r0..r3
`define CPU_REG_CNT 4

// unified program/data memory, bytes
`define CPU_MEM_DEPTH 256

// OR-ed into every data address so loads/stores stay in the upper half
`define CPU_DATA_BASE 8'h80

`endif
